//--- common/timer_pkg.sv
// Timer section definitions
`default_nettype none

package timer_pkg;

    // Counter widths of timer A and timer B.
    localparam int CW_A = 10;
    localparam int CW_B = 8;

    // Prescaler widths, each timer counts over CW + BW bits.
    localparam int BW_A = 6;
    localparam int BW_B = 10;

    // Clock cycles per sample-rate enable pulse.
    localparam int CEN_DIV = 4;
    localparam int CEN_CNT_W = (CEN_DIV > 1) ? $clog2(CEN_DIV) : 1;

    // Request bit positions, same order as the ack struct.
    localparam int N_REQ      = 4;
    localparam int REQ_LOAD_A = 3;
    localparam int REQ_LOAD_B = 2;
    localparam int REQ_CLR_A  = 1;
    localparam int REQ_CLR_B  = 0;

    typedef logic [CW_A-1:0]      value_a_t;
    typedef logic [CW_B-1:0]      value_b_t;
    typedef logic [CEN_CNT_W-1:0] cen_cnt_t;
    typedef logic [N_REQ-1:0]     req_vec_t;

    typedef struct packed {
        value_a_t value_a;
        value_b_t value_b;
        logic     load_a;
        logic     load_b;
        logic     clr_a;
        logic     clr_b;
        logic     irq_en_a;
        logic     irq_en_b;
    } timer_ctrl_t;

    typedef struct packed {
        logic load_ack_a;
        logic load_ack_b;
        logic clr_ack_a;
        logic clr_ack_b;
    } timer_ack_t;

    typedef struct packed {
        logic flag_a;
        logic flag_b;
    } timer_status_t;

endpackage

`default_nettype wire

//--- common/reg_pkg.sv
// Host register map
`default_nettype none

package reg_pkg;

    localparam int REG_W = 8;

    typedef logic [REG_W-1:0] reg_addr_t;
    typedef logic [REG_W-1:0] reg_data_t;

    // Timer A upper 8 bits, then its lower 2 bits.
    localparam reg_addr_t ADDR_A_HI = 8'h10;
    localparam reg_addr_t ADDR_A_LO = 8'h11;
    localparam reg_addr_t ADDR_B    = 8'h12;
    localparam reg_addr_t ADDR_CTRL = 8'h14;

    // Bits of timer A that live in ADDR_A_LO.
    localparam int A_LO_BITS = 2;

    // Control register bit positions.
    localparam int CTRL_LOAD_A  = 0;
    localparam int CTRL_LOAD_B  = 1;
    localparam int CTRL_IRQEN_A = 2;
    localparam int CTRL_IRQEN_B = 3;
    localparam int CTRL_CLR_A   = 4;
    localparam int CTRL_CLR_B   = 5;

    // Single-cycle host write.
    typedef struct packed {
        logic      valid;
        reg_addr_t addr;
        reg_data_t data;
    } reg_wr_t;

endpackage

`default_nettype wire

//--- hw/cen_gen.sv
// Sample-rate clock enable
`timescale 1ns/1ps
`default_nettype none

module cen_gen (
    input  logic clk,
    input  logic rst,
    output logic cen
);

    import timer_pkg::*;

    localparam cen_cnt_t CNT_LAST = cen_cnt_t'(CEN_DIV - 1);

    cen_cnt_t div_cnt;

    // Modulo counter with the pulse registered on the terminal count.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
            cen     <= 1'b0;
        end else begin
            if (div_cnt == CNT_LAST) begin
                div_cnt <= '0;
                cen     <= 1'b1;
            end else begin
                div_cnt <= div_cnt + 1'b1;
                cen     <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/timer_reg_if.sv
// Timer register interface
`timescale 1ns/1ps
`default_nettype none

module timer_reg_if (
    input  logic                  clk,
    input  logic                  rst,
    input  reg_pkg::reg_wr_t      wr,
    input  timer_pkg::timer_ack_t ack,
    output timer_pkg::timer_ctrl_t ctrl
);

    import reg_pkg::*;
    import timer_pkg::*;

    value_a_t value_a_q;
    value_b_t value_b_q;
    logic     irq_en_a_q;
    logic     irq_en_b_q;

    logic     ctrl_wr;
    req_vec_t req_q;
    req_vec_t req_set;
    req_vec_t ack_vec;

    assign ctrl_wr = wr.valid && (wr.addr == ADDR_CTRL);

    // Ack bits share the request ordering.
    assign ack_vec = ack;

    // Value registers only move on a write to their own address.
    always_ff @(posedge clk) begin
        if (wr.valid) begin
            case (wr.addr)
                ADDR_A_HI: value_a_q[CW_A-1:A_LO_BITS] <= wr.data;
                ADDR_A_LO: value_a_q[A_LO_BITS-1:0]    <= wr.data[A_LO_BITS-1:0];
                ADDR_B:    value_b_q                   <= wr.data;
                default:   ;
            endcase
        end
    end

    // New requests from a control write.
    always_comb begin
        req_set = '0;
        if (ctrl_wr) begin
            req_set[REQ_LOAD_A] = wr.data[CTRL_LOAD_A];
            req_set[REQ_LOAD_B] = wr.data[CTRL_LOAD_B];
            req_set[REQ_CLR_A]  = wr.data[CTRL_CLR_A];
            req_set[REQ_CLR_B]  = wr.data[CTRL_CLR_B];
        end
    end

    // A request holds until its ack is seen, a repeat merges into it.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req_q      <= '0;
            irq_en_a_q <= 1'b0;
            irq_en_b_q <= 1'b0;
        end else begin
            req_q <= (req_q & ~ack_vec) | req_set;
            if (ctrl_wr) begin
                irq_en_a_q <= wr.data[CTRL_IRQEN_A];
                irq_en_b_q <= wr.data[CTRL_IRQEN_B];
            end
        end
    end

    assign ctrl.value_a  = value_a_q;
    assign ctrl.value_b  = value_b_q;
    assign ctrl.load_a   = req_q[REQ_LOAD_A];
    assign ctrl.load_b   = req_q[REQ_LOAD_B];
    assign ctrl.clr_a    = req_q[REQ_CLR_A];
    assign ctrl.clr_b    = req_q[REQ_CLR_B];
    assign ctrl.irq_en_a = irq_en_a_q;
    assign ctrl.irq_en_b = irq_en_b_q;

    // No request drops before the timer has acknowledged it.
    assert property (@(posedge clk) disable iff (rst)
        (($past(req_q) & ~req_q & ~$past(ack_vec)) == '0));

endmodule

`default_nettype wire

//--- timers/timer_counter.sv
// Prescaled timer counter
`timescale 1ns/1ps
`default_nettype none

module timer_counter #(
    parameter int CW = 10,
    parameter int BW = 6
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          cen,
    input  logic [CW-1:0] start_value,
    input  logic          load,
    input  logic          clr_flag,
    input  logic          flag_enable,
    output logic          load_ack,
    output logic          clr_ack,
    output logic          flag,
    output logic          overflow
);

    typedef logic [CW+BW-1:0] count_t;

    count_t cnt;
    count_t cnt_start;
    logic   cnt_up;
    logic   wrap_q;

    // Start value sits above the prescaler bits.
    assign cnt_start = {start_value, {BW{1'b0}}};

    // The count advances on the cycle after each enable.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt_up <= 1'b0;
        end else begin
            cnt_up <= cen;
        end
    end

    // No reload on wrap. The counter rolls to zero and carries on.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt      <= '0;
            wrap_q   <= 1'b0;
            load_ack <= 1'b0;
        end else begin
            if (load) begin
                cnt      <= cnt_start;
                wrap_q   <= 1'b0;
                load_ack <= 1'b1;
            end else begin
                load_ack      <= 1'b0;
                {wrap_q, cnt} <= {1'b0, cnt} + {{(CW+BW){1'b0}}, cnt_up};
            end
        end
    end

    // A reload takes priority over a wrap in the same cycle.
    assign overflow = wrap_q & ~load;

    // Sticky flag that the clr handshake resets.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flag    <= 1'b0;
            clr_ack <= 1'b0;
        end else begin
            if (clr_flag) begin
                flag    <= 1'b0;
                clr_ack <= 1'b1;
            end else begin
                clr_ack <= 1'b0;
                if (flag_enable && overflow) begin
                    flag <= 1'b1;
                end
            end
        end
    end

    // The wrap pulse never overlaps a load and only follows a roll to zero.
    assert property (@(posedge clk) disable iff (rst) overflow |-> (!load && cnt == '0));

endmodule

`default_nettype wire

//--- timers/timer_pair.sv
// Timer A and B with interrupt
`timescale 1ns/1ps
`default_nettype none

module timer_pair (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cen,
    input  timer_pkg::timer_ctrl_t   ctrl,
    output timer_pkg::timer_ack_t    ack,
    output timer_pkg::timer_status_t status,
    output logic                     overflow_a,
    output logic                     irq_n
);

    import timer_pkg::*;

    logic flag_a;
    logic flag_b;

    timer_counter #(.CW(CW_A), .BW(BW_A)) i_timer_a (
        .clk         (clk),
        .rst         (rst),
        .cen         (cen),
        .start_value (ctrl.value_a),
        .load        (ctrl.load_a),
        .clr_flag    (ctrl.clr_a),
        .flag_enable (ctrl.irq_en_a),
        .load_ack    (ack.load_ack_a),
        .clr_ack     (ack.clr_ack_a),
        .flag        (flag_a),
        .overflow    (overflow_a)
    );

    // Timer B overflow only matters for the CSM path.
    timer_counter #(.CW(CW_B), .BW(BW_B)) i_timer_b (
        .clk         (clk),
        .rst         (rst),
        .cen         (cen),
        .start_value (ctrl.value_b),
        .load        (ctrl.load_b),
        .clr_flag    (ctrl.clr_b),
        .flag_enable (ctrl.irq_en_b),
        .load_ack    (ack.load_ack_b),
        .clr_ack     (ack.clr_ack_b),
        .flag        (flag_b),
        .overflow    ()
    );

    assign status.flag_a = flag_a;
    assign status.flag_b = flag_b;

    // Active-low interrupt, one cycle behind the flags.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            irq_n <= 1'b1;
        end else begin
            irq_n <= !(flag_a || flag_b);
        end
    end

endmodule

`default_nettype wire

//--- hw/timer_subsys_top.sv
// Timer subsystem top
`timescale 1ns/1ps
`default_nettype none

module timer_subsys_top (
    input  logic                     clk,
    input  logic                     rst,
    input  reg_pkg::reg_wr_t         wr,
    output timer_pkg::timer_status_t status,
    output logic                     irq_n,
    output logic                     overflow_a
);

    import timer_pkg::*;

    timer_ctrl_t ctrl;
    timer_ack_t  ack;
    logic        cen;

    // Host writes into timer controls.
    timer_reg_if i_timer_reg_if (
        .clk  (clk),
        .rst  (rst),
        .wr   (wr),
        .ack  (ack),
        .ctrl (ctrl)
    );

    // Sample-rate enable for both timers.
    cen_gen i_cen_gen (
        .clk (clk),
        .rst (rst),
        .cen (cen)
    );

    timer_pair i_timer_pair (
        .clk        (clk),
        .rst        (rst),
        .cen        (cen),
        .ctrl       (ctrl),
        .ack        (ack),
        .status     (status),
        .overflow_a (overflow_a),
        .irq_n      (irq_n)
    );

endmodule

`default_nettype wire

//--- testbench/tb_timer_model.svh
// Timer reference model and checks
`ifndef TB_TIMER_MODEL_SVH
`define TB_TIMER_MODEL_SVH

// The enable phase against the load moves the first overflow by a few cycles.
localparam int WIN_SLACK = CEN_DIV + 3;

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// Clock cycles from a load write to the first overflow.
function automatic int nominal_cycles(input int cw, input int bw, input int start);
    return ((1 << cw) - start) * (1 << bw) * CEN_DIV;
endfunction

task automatic check_status(input string name, input timer_status_t got,
                            input timer_status_t exp);
    if (got !== exp) begin
        $display("ERROR at time %0t: %s = %b, expected %b", $time, name, got, exp);
        status_errors++;
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("ERROR at time %0t: %s = %b, expected %b", $time, name, got, exp);
        bit_errors++;
    end
endtask

task automatic check_window(input string name, input int cycles, input int nom);
    if (cycles < nom - WIN_SLACK || cycles > nom + WIN_SLACK) begin
        $display("ERROR at time %0t: %s cycles = %0d, expected %0d +/- %0d",
                 $time, name, cycles, nom, WIN_SLACK);
        window_errors++;
    end
endtask

`endif

//--- testbench/tb_timer_subsys.sv
// Timer subsystem testbench
`timescale 1ns/1ps
`default_nettype none

module tb_timer_subsys;

    import timer_pkg::*;
    import reg_pkg::*;

    localparam int WAIT_LIMIT = 20000;
    localparam int NOISE_CYCLES = 64;

    logic          clk;
    logic          rst;
    reg_wr_t       wr;
    timer_status_t status;
    logic          irq_n;
    logic          overflow_a;

    int            status_errors;
    int            bit_errors;
    int            window_errors;
    int            timeout_errors;
    logic [31:0]   rng_state;
    timer_status_t prev_status;
    logic          prev_ovf;

    `include "tb_timer_model.svh"

    timer_subsys_top i_timer_subsys_top (
        .clk        (clk),
        .rst        (rst),
        .wr         (wr),
        .status     (status),
        .irq_n      (irq_n),
        .overflow_a (overflow_a)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // irq_n trails the flags by one cycle and overflow_a lasts a single cycle.
    always @(negedge clk) begin
        if (!rst) begin
            check_bit("irq_n", irq_n, !(prev_status.flag_a || prev_status.flag_b));
            if (prev_ovf) begin
                check_bit("overflow_a", overflow_a, 1'b0);
            end
        end
        prev_status <= status;
        prev_ovf    <= overflow_a;
    end

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Moves a mapped address out of the register map.
    function automatic reg_addr_t unmapped(input reg_addr_t a);
        if (a inside {ADDR_A_HI, ADDR_A_LO, ADDR_B, ADDR_CTRL}) begin
            return a ^ 8'h80;
        end
        return a;
    endfunction

    function automatic reg_data_t ctrl_byte(input logic la, input logic lb, input logic ea,
                                            input logic eb, input logic ca, input logic cb);
        reg_data_t d;
        d = '0;
        d[CTRL_LOAD_A]  = la;
        d[CTRL_LOAD_B]  = lb;
        d[CTRL_IRQEN_A] = ea;
        d[CTRL_IRQEN_B] = eb;
        d[CTRL_CLR_A]   = ca;
        d[CTRL_CLR_B]   = cb;
        return d;
    endfunction

    task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
        @(posedge clk);
        wr <= {1'b1, addr, data};
        @(posedge clk);
        wr <= '0;
    endtask

    task automatic set_value_a(input value_a_t v);
        write_reg(ADDR_A_HI, v[CW_A-1:A_LO_BITS]);
        write_reg(ADDR_A_LO, reg_data_t'(v[A_LO_BITS-1:0]));
    endtask

    task automatic hold_status(input timer_status_t exp, input int n);
        repeat (n) begin
            @(negedge clk);
            check_status("status", status, exp);
            check_bit("overflow_a", overflow_a, 1'b0);
        end
    endtask

    // Counts cycles until the chosen flag rises, optionally with unmapped writes.
    task automatic wait_rise(input logic sel_b, input timer_status_t pre, input logic noise,
                             inout int cycles, output logic ovf_seen);
        timer_status_t post;
        logic          risen;
        logic [31:0]   r;
        post = pre;
        if (sel_b) begin
            post.flag_b = 1'b1;
        end else begin
            post.flag_a = 1'b1;
        end
        risen    = 1'b0;
        ovf_seen = 1'b0;
        while (!risen && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            if (noise && cycles < NOISE_CYCLES) begin
                r = next_rand();
                wr <= {1'b1, unmapped(r[7:0]), r[15:8]};
            end else begin
                wr <= '0;
            end
            @(negedge clk);
            cycles++;
            risen = sel_b ? status.flag_b : status.flag_a;
            if (risen) begin
                check_status("status", status, post);
            end else begin
                check_status("status", status, pre);
                ovf_seen = overflow_a;
            end
        end
        if (!risen) begin
            $display("Timeout: flag %s did not rise", sel_b ? "B" : "A");
            timeout_errors++;
        end
    endtask

    task automatic wait_overflow(inout int cycles);
        logic found;
        found = 1'b0;
        while (!found && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
            found = overflow_a;
        end
        if (!found) begin
            $display("Timeout: overflow_a never pulsed");
            timeout_errors++;
        end
    endtask

    task automatic clear_flag(input logic sel_b, input logic en_a, input logic en_b);
        int   n;
        logic still;
        write_reg(ADDR_CTRL, ctrl_byte(1'b0, 1'b0, en_a, en_b, !sel_b, sel_b));
        n     = 0;
        still = 1'b1;
        while (still && n < 3) begin
            @(negedge clk);
            n++;
            still = sel_b ? status.flag_b : status.flag_a;
        end
        if (still) begin
            $display("Timeout: flag %s was not cleared within 3 cycles", sel_b ? "B" : "A");
            timeout_errors++;
        end
    endtask

    initial begin
        timer_status_t exp;
        int            cycles;
        logic          ovf;
        value_a_t      va;
        value_b_t      vb;
        logic [31:0]   r;
        status_errors  = 0;
        bit_errors     = 0;
        window_errors  = 0;
        timeout_errors = 0;
        rng_state      = 32'h0521_41b4;
        rst = 1'b1;
        wr  = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // Quiet after reset.
        hold_status('0, 20);
        check_bit("irq_n", irq_n, 1'b1);

        // Timer A with its interrupt enabled.
        r  = next_rand();
        va = value_a_t'(1016 + r[2:0]);
        set_value_a(va);
        write_reg(ADDR_CTRL, ctrl_byte(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0));
        cycles = 0;
        wait_rise(1'b0, '0, 1'b0, cycles, ovf);
        check_window("flag_a", cycles, nominal_cycles(CW_A, BW_A, int'(va)));
        check_bit("overflow_a before flag_a", ovf, 1'b1);
        check_bit("irq_n", irq_n, 1'b1);
        @(negedge clk);
        check_bit("irq_n", irq_n, 1'b0);

        // Timer A with its interrupt disabled.
        clear_flag(1'b0, 1'b0, 1'b0);
        hold_status('0, 4);
        r  = next_rand();
        va = value_a_t'(1016 + r[2:0]);
        set_value_a(va);
        write_reg(ADDR_CTRL, ctrl_byte(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0));
        cycles = 0;
        wait_overflow(cycles);
        check_window("overflow_a", cycles, nominal_cycles(CW_A, BW_A, int'(va)));
        hold_status('0, 8);
        check_bit("irq_n", irq_n, 1'b1);

        // Timer B, then its clear.
        r  = next_rand();
        vb = value_b_t'(252 + r[1:0]);
        write_reg(ADDR_B, vb);
        write_reg(ADDR_CTRL, ctrl_byte(1'b0, 1'b1, r[8], 1'b1, 1'b0, 1'b0));
        cycles = 0;
        wait_rise(1'b1, '0, 1'b0, cycles, ovf);
        check_window("flag_b", cycles, nominal_cycles(CW_B, BW_B, int'(vb)));
        clear_flag(1'b1, r[8], 1'b1);
        hold_status('0, 4);
        check_bit("irq_n", irq_n, 1'b1);

        // Both timers. A always wraps well before B.
        r  = next_rand();
        va = value_a_t'(1016 + r[2:0]);
        vb = value_b_t'(252 + r[4:3]);
        set_value_a(va);
        write_reg(ADDR_B, vb);
        write_reg(ADDR_CTRL, ctrl_byte(1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0));
        cycles = 0;
        wait_rise(1'b0, '0, 1'b0, cycles, ovf);
        check_window("flag_a", cycles, nominal_cycles(CW_A, BW_A, int'(va)));
        exp        = '0;
        exp.flag_a = 1'b1;
        wait_rise(1'b1, exp, 1'b0, cycles, ovf);
        check_window("flag_b", cycles, nominal_cycles(CW_B, BW_B, int'(vb)));
        @(negedge clk);
        check_bit("irq_n", irq_n, 1'b0);
        clear_flag(r[5], 1'b1, 1'b1);
        exp = '0;
        if (r[5]) begin
            exp.flag_a = 1'b1;
        end else begin
            exp.flag_b = 1'b1;
        end
        hold_status(exp, 4);
        check_bit("irq_n", irq_n, 1'b0);
        clear_flag(!r[5], 1'b1, 1'b1);
        hold_status('0, 4);
        check_bit("irq_n", irq_n, 1'b1);

        // Unmapped writes while timer A runs.
        r  = next_rand();
        va = value_a_t'(1016 + r[2:0]);
        set_value_a(va);
        write_reg(ADDR_CTRL, ctrl_byte(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0));
        cycles = 0;
        wait_rise(1'b0, '0, 1'b1, cycles, ovf);
        check_window("flag_a", cycles, nominal_cycles(CW_A, BW_A, int'(va)));
        check_bit("overflow_a before flag_a", ovf, 1'b1);

        $display("Errors: status %0d, bit %0d, window %0d, timeout %0d",
                 status_errors, bit_errors, window_errors, timeout_errors);
        if (status_errors + bit_errors + window_errors + timeout_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+testbench
common/timer_pkg.sv
common/reg_pkg.sv
hw/cen_gen.sv
hw/timer_reg_if.sv
timers/timer_counter.sv
timers/timer_pair.sv
hw/timer_subsys_top.sv
testbench/tb_timer_subsys.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_timer_subsys
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test failures found" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@grep -q "All tests passed!" $(LOG) || { echo "Simulation did not finish"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
